//--- hw/tlb_cfg_regs.sv
// ========================================
// Configuration registers: current ASID, entry staging
// registers and the command port that issues maintenance ops
// A CMD write becomes a one-cycle op on the next cycle
// ========================================

`timescale 1ns/100ps

module tlb_cfg_regs (
  input  logic               clk,
  input  logic               s_rst_n,
  input  logic               cfg_we_i,
  input  tlb_pkg::cfg_addr_e cfg_addr_i,
  input  logic [31:0]        cfg_wdata_i,
  output logic [31:0]        cfg_rdata_o,
  tlb_maint_if.cfg           maint
);

  logic [tlb_pkg::ASID_W-1:0] asid_q;
  logic [tlb_pkg::VPPN_W-1:0] ehi_q;
  logic [31:0]                elo0_q;
  logic [31:0]                elo1_q;
  logic [tlb_pkg::IDX_W-1:0]  idx_q;
  logic [5:0]                 ps_q;
  logic                       ne_q;
  logic [tlb_pkg::VPPN_W-1:0] inv_vppn_q;
  tlb_pkg::maint_op_e         op_q;
  tlb_pkg::inv_opt_e          inv_opt_q;

  // Rebuild an ELO word from one half of an entry
  function automatic logic [31:0] elo_word(tlb_pkg::tlb_entry_t e, logic odd);
    return {4'b0, e.ppn[odd], 1'b0, e.glo, e.mat[odd], e.plv[odd],
            e.dirty[odd], e.valid[odd]};
  endfunction

  always_ff @(posedge clk or negedge s_rst_n) begin
    if (!s_rst_n) begin
      asid_q     <= '0;
      ehi_q      <= '0;
      elo0_q     <= '0;
      elo1_q     <= '0;
      idx_q      <= '0;
      ps_q       <= '0;
      ne_q       <= 1'b0;
      inv_vppn_q <= '0;
      op_q       <= tlb_pkg::OP_NONE;
      inv_opt_q  <= tlb_pkg::INV_ALL0;
    end else begin
      op_q <= tlb_pkg::OP_NONE;
      // Read-back lands at the op edge
      if (op_q == tlb_pkg::OP_READ) begin
        ehi_q  <= maint.rd_entry.vppn;
        elo0_q <= elo_word(maint.rd_entry, 1'b0);
        elo1_q <= elo_word(maint.rd_entry, 1'b1);
        ps_q   <= maint.rd_entry.page_size;
        ne_q   <= !maint.rd_entry.exist;
      end
      if (cfg_we_i) begin
        case (cfg_addr_i)
          tlb_pkg::CFG_ASID:   asid_q <= cfg_wdata_i[tlb_pkg::ASID_W-1:0];
          tlb_pkg::CFG_EHI:    ehi_q  <= cfg_wdata_i[31:13];
          tlb_pkg::CFG_ELO0:   elo0_q <= cfg_wdata_i & tlb_pkg::ELO_MASK;
          tlb_pkg::CFG_ELO1:   elo1_q <= cfg_wdata_i & tlb_pkg::ELO_MASK;
          tlb_pkg::CFG_IDX: begin
            idx_q <= cfg_wdata_i[tlb_pkg::IDX_W-1:0];
            ps_q  <= cfg_wdata_i[29:24];
            ne_q  <= cfg_wdata_i[31];
          end
          tlb_pkg::CFG_CMD: begin
            op_q      <= tlb_pkg::maint_op_e'(cfg_wdata_i[1:0]);
            inv_opt_q <= tlb_pkg::inv_opt_e'(cfg_wdata_i[6:4]);
          end
          tlb_pkg::CFG_INV_VA: inv_vppn_q <= cfg_wdata_i[31:13];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (cfg_addr_i)
      tlb_pkg::CFG_ASID:   cfg_rdata_o = {22'b0, asid_q};
      tlb_pkg::CFG_EHI:    cfg_rdata_o = {ehi_q, 13'b0};
      tlb_pkg::CFG_ELO0:   cfg_rdata_o = elo0_q;
      tlb_pkg::CFG_ELO1:   cfg_rdata_o = elo1_q;
      tlb_pkg::CFG_IDX:    cfg_rdata_o = {ne_q, 1'b0, ps_q, 20'b0, idx_q};
      tlb_pkg::CFG_INV_VA: cfg_rdata_o = {inv_vppn_q, 13'b0};
      default:             cfg_rdata_o = '0;
    endcase
  end

  // ========================================
  // Maintenance op assembled from staging
  // ========================================
  assign maint.op      = op_q;
  assign maint.idx     = idx_q;
  assign maint.inv_opt = inv_opt_q;
  assign maint.asid    = asid_q;
  assign maint.vppn    = inv_vppn_q;

  always_comb begin
    maint.entry.exist     = !ne_q;
    // Global only when both halves say so
    maint.entry.glo       = elo0_q[6] & elo1_q[6];
    maint.entry.asid      = asid_q;
    maint.entry.vppn      = ehi_q;
    maint.entry.page_size = ps_q;
    maint.entry.valid     = {elo1_q[0], elo0_q[0]};
    maint.entry.dirty     = {elo1_q[1], elo0_q[1]};
    maint.entry.plv       = {elo1_q[3:2], elo0_q[3:2]};
    maint.entry.mat       = {elo1_q[5:4], elo0_q[5:4]};
    maint.entry.ppn       = {elo1_q[27:8], elo0_q[27:8]};
  end

endmodule

//--- hw/tlb_entry_store.sv
// ========================================
// Fully associative entry store
// Applies write and invalidate ops, serves read-back, and
// registers one lookup per dequeued request
// Lookups stall while any maintenance op is active
// ========================================

`timescale 1ns/100ps

module tlb_entry_store (
  input  logic                 clk,
  input  logic                 s_rst_n,
  input  logic                 deq_i,
  input  tlb_pkg::lookup_req_t deq_req_i,
  output logic                 stall_o,
  tlb_maint_if.store           maint,
  tlb_lookup_if.store          lookup
);

  tlb_pkg::tlb_entry_t [tlb_pkg::ENTRY_NUM-1:0] entries_q;

  logic [tlb_pkg::ENTRY_NUM-1:0] match;
  logic [tlb_pkg::ENTRY_NUM-1:0] asid_eq;
  logic [tlb_pkg::ENTRY_NUM-1:0] va_eq;
  logic [tlb_pkg::ENTRY_NUM-1:0] inv_hit;
  logic [tlb_pkg::IDX_W-1:0]     hit_idx;
  tlb_pkg::tlb_entry_t           hit_entry;
  logic                          odd;

  // Page compare above bit 13 for 4 KB, above bit 22 for 2 MB
  function automatic logic vpn_match(tlb_pkg::tlb_entry_t e,
                                     logic [tlb_pkg::VPPN_W-1:0] vppn);
    if (e.page_size == tlb_pkg::PS_4K) begin
      return e.vppn == vppn;
    end
    return e.vppn[18:9] == vppn[18:9];
  endfunction

  assign stall_o        = (maint.op != tlb_pkg::OP_NONE);
  assign maint.rd_entry = entries_q[maint.idx];

  // ========================================
  // Associative match
  // ========================================
  always_comb begin
    hit_idx   = '0;
    hit_entry = '0;
    for (int i = 0; i < tlb_pkg::ENTRY_NUM; i++) begin
      match[i] = entries_q[i].exist &&
                 (entries_q[i].glo || entries_q[i].asid == maint.asid) &&
                 vpn_match(entries_q[i], deq_req_i.va[31:13]);
      // At most one entry matches, so OR-ing selects it
      if (match[i]) begin
        hit_idx   = hit_idx | i[tlb_pkg::IDX_W-1:0];
        hit_entry = hit_entry | entries_q[i];
      end
    end
  end

  assign odd = (hit_entry.page_size == tlb_pkg::PS_4K) ? deq_req_i.va[12] : deq_req_i.va[21];

  always_ff @(posedge clk or negedge s_rst_n) begin
    if (!s_rst_n) begin
      lookup.rvalid <= 1'b0;
    end else begin
      lookup.rvalid <= deq_i;
    end
  end

  always_ff @(posedge clk) begin
    lookup.req       <= deq_req_i;
    lookup.hit       <= |match;
    lookup.hit_idx   <= hit_idx;
    lookup.page_size <= hit_entry.page_size;
    lookup.valid     <= hit_entry.valid[odd];
    lookup.dirty     <= hit_entry.dirty[odd];
    lookup.plv       <= hit_entry.plv[odd];
    lookup.mat       <= hit_entry.mat[odd];
    lookup.ppn       <= hit_entry.ppn[odd];
  end

  // ========================================
  // Write and invalidate
  // ========================================
  always_comb begin
    for (int i = 0; i < tlb_pkg::ENTRY_NUM; i++) begin
      asid_eq[i] = (entries_q[i].asid == maint.asid);
      va_eq[i]   = vpn_match(entries_q[i], maint.vppn);
      case (maint.inv_opt)
        tlb_pkg::INV_ALL0,
        tlb_pkg::INV_ALL1:         inv_hit[i] = 1'b1;
        tlb_pkg::INV_GLO1:         inv_hit[i] = entries_q[i].glo;
        tlb_pkg::INV_GLO0:         inv_hit[i] = !entries_q[i].glo;
        tlb_pkg::INV_GLO0_ASID:    inv_hit[i] = !entries_q[i].glo && asid_eq[i];
        tlb_pkg::INV_GLO0_ASID_VA: inv_hit[i] = !entries_q[i].glo && asid_eq[i] && va_eq[i];
        tlb_pkg::INV_GLO1_ASID_VA: inv_hit[i] = entries_q[i].glo && asid_eq[i] && va_eq[i];
        default:                   inv_hit[i] = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk or negedge s_rst_n) begin
    if (!s_rst_n) begin
      entries_q <= '0;
    end else if (maint.op == tlb_pkg::OP_WRITE) begin
      entries_q[maint.idx] <= maint.entry;
    end else if (maint.op == tlb_pkg::OP_INV) begin
      for (int i = 0; i < tlb_pkg::ENTRY_NUM; i++) begin
        if (inv_hit[i]) begin
          entries_q[i] <= '0;
        end
      end
    end
  end

endmodule

//--- hw/tlb_lookup_if.sv
// ========================================
// Registered lookup result, passed from the entry store
// to the translation stage one cycle after dequeue
// ========================================

`timescale 1ns/100ps

interface tlb_lookup_if;

  logic                         rvalid;
  tlb_pkg::lookup_req_t         req;
  logic                         hit;
  logic [tlb_pkg::IDX_W-1:0]    hit_idx;
  logic [5:0]                   page_size;
  // Fields of the half picked by the parity bit
  logic                         valid;
  logic                         dirty;
  logic [1:0]                   plv;
  logic [1:0]                   mat;
  logic [tlb_pkg::PPN_W-1:0]    ppn;

  modport store (
    output rvalid, req, hit, hit_idx, page_size, valid, dirty, plv, mat, ppn
  );

  modport xlate (
    input  rvalid, req, hit, hit_idx, page_size, valid, dirty, plv, mat, ppn
  );

endinterface

//--- hw/tlb_maint_if.sv
// ========================================
// Maintenance channel between the register block and the
// entry store, plus the combinational read-back entry
// ========================================

`timescale 1ns/100ps

interface tlb_maint_if;

  // Any op other than OP_NONE is a single-cycle pulse
  tlb_pkg::maint_op_e                op;
  logic [tlb_pkg::IDX_W-1:0]         idx;
  tlb_pkg::tlb_entry_t               entry;
  tlb_pkg::inv_opt_e                 inv_opt;
  // Current ASID, used for lookups and invalidation
  logic [tlb_pkg::ASID_W-1:0]        asid;
  logic [tlb_pkg::VPPN_W-1:0]        vppn;
  tlb_pkg::tlb_entry_t               rd_entry;

  modport cfg (
    output op, idx, entry, inv_opt, asid, vppn,
    input  rd_entry
  );

  modport store (
    input  op, idx, entry, inv_opt, asid, vppn,
    output rd_entry
  );

endinterface

//--- hw/tlb_pkg.sv
// ========================================
// Shared sizes, entry and request types, register map and
// opcode encodings for the TLB subsystem
// Other files refer to these by scoped names
// ========================================

package tlb_pkg;

  localparam int VA_W        = 32;
  localparam int ENTRY_NUM   = 16;
  localparam int IDX_W       = 4;
  localparam int ASID_W      = 10;
  localparam int PPN_W       = 20;
  localparam int VPPN_W      = 19;
  localparam int QUEUE_DEPTH = 4;
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

  // Page size field values, 4 KB and 2 MB
  localparam logic [5:0] PS_4K = 6'd12;
  localparam logic [5:0] PS_2M = 6'd21;

  // ELO word: [0] V, [1] D, [3:2] PLV, [5:4] MAT, [6] G, [27:8] PPN
  localparam logic [31:0] ELO_MASK = 32'h0FFF_FF7F;

  // One entry maps an even/odd page pair, index 1 is the odd half
  typedef struct packed {
    logic                        exist;
    logic                        glo;
    logic [ASID_W-1:0]           asid;
    logic [VPPN_W-1:0]           vppn;
    logic [5:0]                  page_size;
    logic [1:0]                  valid;
    logic [1:0]                  dirty;
    logic [1:0][1:0]             plv;
    logic [1:0][1:0]             mat;
    logic [1:0][PPN_W-1:0]       ppn;
  } tlb_entry_t;

  typedef struct packed {
    logic [VA_W-1:0] va;
    logic            store;
    logic [1:0]      plv;
  } lookup_req_t;

  // ========================================
  // Register map and command encodings
  // ========================================

  // IDX word: [3:0] index, [29:24] page size, [31] not-exist
  // CMD word: [1:0] op, [6:4] invalidate option
  typedef enum logic [2:0] {
    CFG_ASID   = 3'd0,
    CFG_EHI    = 3'd1,
    CFG_ELO0   = 3'd2,
    CFG_ELO1   = 3'd3,
    CFG_IDX    = 3'd4,
    CFG_CMD    = 3'd5,
    CFG_INV_VA = 3'd6
  } cfg_addr_e;

  typedef enum logic [1:0] {
    OP_NONE  = 2'd0,
    OP_WRITE = 2'd1,
    OP_READ  = 2'd2,
    OP_INV   = 2'd3
  } maint_op_e;

  typedef enum logic [2:0] {
    INV_ALL0         = 3'd0,
    INV_ALL1         = 3'd1,
    INV_GLO1         = 3'd2,
    INV_GLO0         = 3'd3,
    INV_GLO0_ASID    = 3'd4,
    INV_GLO0_ASID_VA = 3'd5,
    INV_GLO1_ASID_VA = 3'd6
  } inv_opt_e;

  typedef enum logic [2:0] {
    EXC_NONE    = 3'd0,
    EXC_REFILL  = 3'd1,
    EXC_INVALID = 3'd2,
    EXC_PRIV    = 3'd3,
    EXC_MODIFY  = 3'd4
  } tlb_exc_e;

endpackage

//--- hw/tlb_req_queue.sv
// ========================================
// Four-deep request queue with credit return
// One credit comes back the cycle after each dequeue
// ========================================

`timescale 1ns/100ps

module tlb_req_queue (
  input  logic                 clk,
  input  logic                 s_rst_n,
  input  logic                 req_valid_i,
  input  tlb_pkg::lookup_req_t req_i,
  output logic                 credit_o,
  input  logic                 stall_i,
  output logic                 deq_o,
  output tlb_pkg::lookup_req_t deq_req_o
);

  tlb_pkg::lookup_req_t            mem_q [tlb_pkg::QUEUE_DEPTH];
  // Pointers carry one wrap bit
  logic [tlb_pkg::QUEUE_PTR_W:0]   wr_ptr_q;
  logic [tlb_pkg::QUEUE_PTR_W:0]   rd_ptr_q;
  logic [tlb_pkg::QUEUE_PTR_W:0]   count;

  assign count     = wr_ptr_q - rd_ptr_q;
  assign deq_o     = (count != '0) && !stall_i;
  assign deq_req_o = mem_q[rd_ptr_q[tlb_pkg::QUEUE_PTR_W-1:0]];

  always_ff @(posedge clk or negedge s_rst_n) begin
    if (!s_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      credit_o <= 1'b0;
    end else begin
      if (req_valid_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (deq_o) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      credit_o <= deq_o;
    end
  end

  // Storage only
  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      mem_q[wr_ptr_q[tlb_pkg::QUEUE_PTR_W-1:0]] <= req_i;
    end
  end

endmodule

//--- hw/tlb_top.sv
// ========================================
// TLB subsystem top level
// Credit-based request port, register port for maintenance,
// in-order translation responses
// ========================================

`timescale 1ns/100ps

module tlb_top (
  input  logic                     clk,
  input  logic                     s_rst_n,
  // Lookup requests
  input  logic                     req_valid_i,
  input  logic [tlb_pkg::VA_W-1:0] req_va_i,
  input  logic                     req_store_i,
  input  logic [1:0]               req_plv_i,
  output logic                     credit_o,
  // Register port
  input  logic                     cfg_we_i,
  input  tlb_pkg::cfg_addr_e       cfg_addr_i,
  input  logic [31:0]              cfg_wdata_i,
  output logic [31:0]              cfg_rdata_o,
  // Responses
  output logic                     rsp_valid_o,
  output logic [tlb_pkg::VA_W-1:0] rsp_pa_o,
  output tlb_pkg::tlb_exc_e        rsp_exc_o,
  output logic [1:0]               rsp_mat_o
);

  logic                 stall;
  logic                 deq;
  tlb_pkg::lookup_req_t deq_req;

  tlb_maint_if  maint_if ();
  tlb_lookup_if lookup_if ();

  tlb_cfg_regs i_cfg_regs (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .maint       (maint_if.cfg)
  );

  tlb_req_queue i_req_queue (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .req_valid_i (req_valid_i),
    .req_i       ({req_va_i, req_store_i, req_plv_i}),
    .credit_o    (credit_o),
    .stall_i     (stall),
    .deq_o       (deq),
    .deq_req_o   (deq_req)
  );

  tlb_entry_store i_entry_store (
    .clk       (clk),
    .s_rst_n   (s_rst_n),
    .deq_i     (deq),
    .deq_req_i (deq_req),
    .stall_o   (stall),
    .maint     (maint_if.store),
    .lookup    (lookup_if.store)
  );

  tlb_translate i_translate (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .lookup      (lookup_if.xlate),
    .rsp_valid_o (rsp_valid_o),
    .rsp_pa_o    (rsp_pa_o),
    .rsp_exc_o   (rsp_exc_o),
    .rsp_mat_o   (rsp_mat_o)
  );

endmodule

//--- hw/tlb_translate.sv
// ========================================
// Translation stage: forms the physical address and checks
// the hit entry, one registered stage after the lookup
// ========================================

`timescale 1ns/100ps

module tlb_translate (
  input  logic                    clk,
  input  logic                    s_rst_n,
  tlb_lookup_if.xlate             lookup,
  output logic                    rsp_valid_o,
  output logic [tlb_pkg::VA_W-1:0] rsp_pa_o,
  output tlb_pkg::tlb_exc_e       rsp_exc_o,
  output logic [1:0]              rsp_mat_o
);

  logic [tlb_pkg::VA_W-1:0] pa;
  tlb_pkg::tlb_exc_e        exc;

  always_comb begin
    // Page offset width follows the page size
    if (lookup.page_size == tlb_pkg::PS_4K) begin
      pa = {lookup.ppn, lookup.req.va[11:0]};
    end else begin
      pa = {lookup.ppn[tlb_pkg::PPN_W-1:9], lookup.req.va[20:0]};
    end

    // Checked in priority order
    if (!lookup.hit) begin
      exc = tlb_pkg::EXC_REFILL;
    end else if (!lookup.valid) begin
      exc = tlb_pkg::EXC_INVALID;
    end else if (lookup.req.plv > lookup.plv) begin
      exc = tlb_pkg::EXC_PRIV;
    end else if (lookup.req.store && !lookup.dirty) begin
      exc = tlb_pkg::EXC_MODIFY;
    end else begin
      exc = tlb_pkg::EXC_NONE;
    end
  end

  always_ff @(posedge clk or negedge s_rst_n) begin
    if (!s_rst_n) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= lookup.rvalid;
    end
  end

  always_ff @(posedge clk) begin
    rsp_pa_o  <= (exc == tlb_pkg::EXC_NONE) ? pa : '0;
    rsp_exc_o <= exc;
    rsp_mat_o <= lookup.mat;
  end

endmodule

//--- sim/tlb_chk.sv
// ========================================
// Concurrent checks on the request queue, bound into
// every tlb_req_queue instance
// ========================================

`timescale 1ns/100ps

module tlb_chk (
  input logic                            clk,
  input logic                            s_rst_n,
  input logic                            req_valid_i,
  input logic                            deq_o,
  input logic                            credit_o,
  input logic [tlb_pkg::QUEUE_PTR_W:0]   count
);

  // Requests sent and not yet credited back
  logic [tlb_pkg::QUEUE_PTR_W+1:0] in_flight_q;

  always_ff @(posedge clk or negedge s_rst_n) begin
    if (!s_rst_n) begin
      in_flight_q <= '0;
    end else begin
      in_flight_q <= in_flight_q + req_valid_i - credit_o;
    end
  end

  // A request may only arrive while there is room
  a_no_overflow: assert property (@(posedge clk) disable iff (!s_rst_n)
    req_valid_i |-> count < tlb_pkg::QUEUE_DEPTH)
    else $error("request queue overflow");

  a_count_bound: assert property (@(posedge clk) disable iff (!s_rst_n)
    count <= tlb_pkg::QUEUE_DEPTH)
    else $error("request queue count above depth");

  // A returned credit belongs to a request that already left the queue
  a_credit_after_deq: assert property (@(posedge clk) disable iff (!s_rst_n)
    credit_o |-> in_flight_q > count)
    else $error("credit returned without a dequeue");

  // Something must still wait beyond a credit already on its way back
  a_deq_not_empty: assert property (@(posedge clk) disable iff (!s_rst_n)
    deq_o |-> in_flight_q > credit_o)
    else $error("dequeue with no request waiting");

endmodule

bind tlb_req_queue tlb_chk i_chk (
  .clk         (clk),
  .s_rst_n     (s_rst_n),
  .req_valid_i (req_valid_i),
  .deq_o       (deq_o),
  .credit_o    (credit_o),
  .count       (count)
);

//--- sim/tlb_tb.sv
// ========================================
// Testbench for the TLB subsystem: translations, exception
// priority, read-back, the seven invalidate options and a
// random credit-limited phase, checked against a model
// ========================================

`timescale 1ns/100ps

module tlb_tb;

  localparam int N_RAND       = 200;
  // Requests over the directed, invalidate and random phases
  localparam int N_REQ        = 33 + 7 * 16 + N_RAND;
  localparam int SETUP_CYCLES = 3000;

  typedef struct packed {
    logic [31:0]       pa;
    tlb_pkg::tlb_exc_e exc;
    logic [1:0]        mat;
  } exp_t;

  logic                       clk;
  logic                       s_rst_n;
  logic                       req_valid;
  logic [31:0]                req_va;
  logic                       req_store;
  logic [1:0]                 req_plv;
  logic                       credit;
  logic                       cfg_we;
  tlb_pkg::cfg_addr_e         cfg_addr;
  logic [31:0]                cfg_wdata;
  logic [31:0]                cfg_rdata;
  logic                       rsp_valid;
  logic [31:0]                rsp_pa;
  tlb_pkg::tlb_exc_e          rsp_exc;
  logic [1:0]                 rsp_mat;

  // Model of the entry store and the current ASID
  tlb_pkg::tlb_entry_t        model [tlb_pkg::ENTRY_NUM];
  logic [tlb_pkg::ASID_W-1:0] cur_asid;
  logic [31:0]                base_va [4];
  logic [31:0]                odd_off [4];
  logic [31:0]                wr_elo0 [4];
  logic [31:0]                wr_elo1 [4];
  logic [5:0]                 wr_ps [4];
  exp_t                       exp_q [$];
  int                         n_sent;
  int                         n_ret;
  int                         n_val_err;
  int                         n_other_err;
  integer                     seed;
  logic [31:0]                r;
  logic [31:0]                rand_va;
  int                         k;

  tlb_top i_dut (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .req_valid_i (req_valid),
    .req_va_i    (req_va),
    .req_store_i (req_store),
    .req_plv_i   (req_plv),
    .credit_o    (credit),
    .cfg_we_i    (cfg_we),
    .cfg_addr_i  (cfg_addr),
    .cfg_wdata_i (cfg_wdata),
    .cfg_rdata_o (cfg_rdata),
    .rsp_valid_o (rsp_valid),
    .rsp_pa_o    (rsp_pa),
    .rsp_exc_o   (rsp_exc),
    .rsp_mat_o   (rsp_mat)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ========================================
  // Reference model
  // ========================================
  function automatic logic [31:0] elo(logic [19:0] ppn, logic g, logic [1:0] mat,
                                      logic [1:0] plv, logic d, logic v);
    return {4'h0, ppn, 1'b0, g, mat, plv, d, v};
  endfunction

  function automatic logic page_match(tlb_pkg::tlb_entry_t e, logic [31:0] va);
    if (e.page_size == tlb_pkg::PS_4K) begin
      return e.vppn == va[31:13];
    end
    return e.vppn[18:9] == va[31:22];
  endfunction

  function automatic exp_t tlb_ref(logic [31:0] va, logic store, logic [1:0] plv);
    exp_t                r;
    int                  hit;
    logic                odd;
    tlb_pkg::tlb_entry_t e;
    r   = '0;
    hit = -1;
    for (int i = 0; i < tlb_pkg::ENTRY_NUM; i++) begin
      if (model[i].exist && (model[i].glo || model[i].asid == cur_asid) &&
          page_match(model[i], va)) begin
        hit = i;
      end
    end
    if (hit < 0) begin
      r.exc = tlb_pkg::EXC_REFILL;
      return r;
    end
    e     = model[hit];
    odd   = (e.page_size == tlb_pkg::PS_4K) ? va[12] : va[21];
    r.mat = e.mat[odd];
    if (!e.valid[odd]) begin
      r.exc = tlb_pkg::EXC_INVALID;
    end else if (plv > e.plv[odd]) begin
      r.exc = tlb_pkg::EXC_PRIV;
    end else if (store && !e.dirty[odd]) begin
      r.exc = tlb_pkg::EXC_MODIFY;
    end else begin
      r.exc = tlb_pkg::EXC_NONE;
      r.pa  = (e.page_size == tlb_pkg::PS_4K) ? {e.ppn[odd], va[11:0]} :
                                                {e.ppn[odd][19:9], va[20:0]};
    end
    return r;
  endfunction

  function automatic logic inv_match(tlb_pkg::tlb_entry_t e, tlb_pkg::inv_opt_e opt,
                                     logic [31:0] va);
    logic same_asid;
    logic same_va;
    same_asid = (e.asid == cur_asid);
    same_va   = page_match(e, va);
    case (opt)
      tlb_pkg::INV_ALL0, tlb_pkg::INV_ALL1: return 1'b1;
      tlb_pkg::INV_GLO1:         return e.glo;
      tlb_pkg::INV_GLO0:         return !e.glo;
      tlb_pkg::INV_GLO0_ASID:    return !e.glo && same_asid;
      tlb_pkg::INV_GLO0_ASID_VA: return !e.glo && same_asid && same_va;
      tlb_pkg::INV_GLO1_ASID_VA: return e.glo && same_asid && same_va;
      default:                   return 1'b0;
    endcase
  endfunction

  // ========================================
  // Register port and request tasks
  // ========================================
  task automatic cfg_write(input tlb_pkg::cfg_addr_e a, input logic [31:0] d);
    cfg_we    = 1'b1;
    cfg_addr  = a;
    cfg_wdata = d;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
  endtask

  task automatic set_asid(input logic [tlb_pkg::ASID_W-1:0] a);
    cfg_write(tlb_pkg::CFG_ASID, {22'h0, a});
    cur_asid = a;
  endtask

  task automatic write_entry(input int idx, input logic [5:0] ps,
                             input logic [31:0] elo0, input logic [31:0] elo1);
    tlb_pkg::tlb_entry_t e;
    cfg_write(tlb_pkg::CFG_EHI, base_va[idx]);
    cfg_write(tlb_pkg::CFG_ELO0, elo0);
    cfg_write(tlb_pkg::CFG_ELO1, elo1);
    cfg_write(tlb_pkg::CFG_IDX, {2'b00, ps, 20'h0, 4'(idx)});
    cfg_write(tlb_pkg::CFG_CMD, {30'h0, tlb_pkg::OP_WRITE});
    e           = '0;
    e.exist     = 1'b1;
    e.glo       = elo0[6] & elo1[6];
    e.asid      = cur_asid;
    e.vppn      = base_va[idx][31:13];
    e.page_size = ps;
    e.valid     = {elo1[0], elo0[0]};
    e.dirty     = {elo1[1], elo0[1]};
    e.plv       = {elo1[3:2], elo0[3:2]};
    e.mat       = {elo1[5:4], elo0[5:4]};
    e.ppn       = {elo1[27:8], elo0[27:8]};
    model[idx]   = e;
    wr_elo0[idx] = elo0;
    wr_elo1[idx] = elo1;
    wr_ps[idx]   = ps;
  endtask

  // Two 4 KB and two 2 MB pairs, one global, one under ASID 7
  task automatic populate();
    set_asid(10'h005);
    write_entry(0, tlb_pkg::PS_4K, elo(20'h12345, 1'b0, 2'd1, 2'd3, 1'b1, 1'b1),
                elo(20'h0ABCD, 1'b0, 2'd2, 2'd0, 1'b0, 1'b1));
    write_entry(1, tlb_pkg::PS_2M, elo(20'h00A00, 1'b1, 2'd1, 2'd3, 1'b1, 1'b1),
                elo(20'h00C00, 1'b1, 2'd0, 2'd3, 1'b1, 1'b0));
    write_entry(2, tlb_pkg::PS_4K, elo(20'h55555, 1'b0, 2'd0, 2'd1, 1'b0, 1'b1),
                elo(20'h66666, 1'b0, 2'd3, 2'd3, 1'b1, 1'b1));
    set_asid(10'h007);
    write_entry(3, tlb_pkg::PS_2M, elo(20'h7F200, 1'b0, 2'd1, 2'd2, 1'b1, 1'b1),
                elo(20'h7F400, 1'b0, 2'd1, 2'd0, 1'b0, 1'b1));
    set_asid(10'h005);
  endtask

  task automatic invalidate(input tlb_pkg::inv_opt_e opt, input logic [31:0] va);
    cfg_write(tlb_pkg::CFG_INV_VA, va);
    cfg_write(tlb_pkg::CFG_CMD, {25'h0, opt, 2'b00, tlb_pkg::OP_INV});
    for (int i = 0; i < tlb_pkg::ENTRY_NUM; i++) begin
      if (inv_match(model[i], opt, va)) begin
        model[i] = '0;
      end
    end
  endtask

  // Sends only while a credit is held
  task automatic send_req(input logic [31:0] va, input logic store, input logic [1:0] plv);
    while (n_sent - n_ret >= tlb_pkg::QUEUE_DEPTH) begin
      @(posedge clk);
      #1;
    end
    exp_q.push_back(tlb_ref(va, store, plv));
    req_valid = 1'b1;
    req_va    = va;
    req_store = store;
    req_plv   = plv;
    n_sent++;
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0 || n_ret != n_sent) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic check_reg(input tlb_pkg::cfg_addr_e a, input logic [31:0] exp_val);
    cfg_addr = a;
    #1;
    assert (cfg_rdata == exp_val) else begin
      n_val_err++;
      $display("[FAIL] cfg_rdata_o reg %0d got %h expected %h", a, cfg_rdata, exp_val);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic probe_all();
    for (int a = 0; a < 2; a++) begin
      set_asid((a == 0) ? 10'h005 : 10'h007);
      for (int j = 0; j < 4; j++) begin
        send_req(base_va[j] | 32'h10, 1'b0, 2'd0);
        send_req(base_va[j] | odd_off[j], 1'b1, 2'd3);
      end
      wait_drain();
    end
    set_asid(10'h005);
  endtask

  // ========================================
  // Response compare and credit count
  // ========================================
  always @(negedge clk) begin
    exp_t e;
    if (s_rst_n) begin
      if (credit) begin
        n_ret++;
      end
      assert (n_ret <= n_sent) else begin
        n_other_err++;
        $display("more credits returned than requests sent, sent %0d returned %0d",
                 n_sent, n_ret);
      end
      if (rsp_valid) begin
        assert (exp_q.size() != 0) else begin
          n_other_err++;
          $display("response arrived with no request outstanding");
        end
        if (exp_q.size() != 0) begin
          e = exp_q.pop_front();
          assert (rsp_exc == e.exc) else begin
            n_val_err++;
            $display("[FAIL] rsp_exc_o got %h expected %h", rsp_exc, e.exc);
          end
          assert (rsp_pa == e.pa) else begin
            n_val_err++;
            $display("[FAIL] rsp_pa_o got %h expected %h", rsp_pa, e.pa);
          end
          assert (rsp_mat == e.mat) else begin
            n_val_err++;
            $display("[FAIL] rsp_mat_o got %h expected %h", rsp_mat, e.mat);
          end
        end
      end
    end
  end

  initial begin
    repeat (N_REQ * 40 + SETUP_CYCLES) @(posedge clk);
    $display("watchdog expired before all responses and credits came back");
    $display(">>> FAIL");
    $finish;
  end

  // ========================================
  // Stimulus
  // ========================================
  initial begin
    base_va     = '{32'h0002_0000, 32'h0040_0000, 32'h0004_0000, 32'h0080_0000};
    odd_off     = '{32'h0000_1000, 32'h0020_0000, 32'h0000_1000, 32'h0020_0000};
    s_rst_n     = 1'b0;
    req_valid   = 1'b0;
    req_va      = '0;
    req_store   = 1'b0;
    req_plv     = '0;
    cfg_we      = 1'b0;
    cfg_addr    = tlb_pkg::CFG_ASID;
    cfg_wdata   = '0;
    cur_asid    = '0;
    n_sent      = 0;
    n_ret       = 0;
    n_val_err   = 0;
    n_other_err = 0;
    seed        = 32'h50817295;
    for (int i = 0; i < tlb_pkg::ENTRY_NUM; i++) begin
      model[i] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    s_rst_n = 1'b1;
    @(posedge clk);
    #1;

    // Both halves, both page sizes, loads and stores at plv 0 and 3
    populate();
    for (int j = 0; j < 4; j++) begin
      for (int h = 0; h < 2; h++) begin
        for (int s = 0; s < 2; s++) begin
          for (int p = 0; p < 2; p++) begin
            send_req(base_va[j] | (h ? odd_off[j] : 32'h0) | 32'h0ABC, s[0], 2'(p * 3));
          end
        end
      end
    end
    send_req(32'h1234_5678, 1'b0, 2'd0);
    wait_drain();

    // Read-back through the staging registers
    for (int j = 0; j < 4; j++) begin
      cfg_write(tlb_pkg::CFG_IDX, j);
      cfg_write(tlb_pkg::CFG_CMD, {30'h0, tlb_pkg::OP_READ});
      @(posedge clk);
      #1;
      check_reg(tlb_pkg::CFG_EHI, base_va[j]);
      check_reg(tlb_pkg::CFG_ELO0, wr_elo0[j]);
      check_reg(tlb_pkg::CFG_ELO1, wr_elo1[j]);
      check_reg(tlb_pkg::CFG_IDX, {2'b00, wr_ps[j], 20'h0, 4'(j)});
    end

    // Each invalidate option on a fresh set of entries
    for (int o = 0; o < 7; o++) begin
      populate();
      invalidate(tlb_pkg::inv_opt_e'(o), (o == 6) ? base_va[1] : base_va[0]);
      probe_all();
    end

    // Random traffic with read commands stalling the queue
    populate();
    for (int n = 0; n < N_RAND; n++) begin
      r = $random(seed);
      k = r[1:0];
      if (r[4:2] == 3'd0) begin
        rand_va = $random(seed);
      end else begin
        rand_va = base_va[k] | ($random(seed) & ((odd_off[k] << 1) - 1));
      end
      send_req(rand_va, r[5], r[7:6]);
      if (r[11:8] == 4'h0) begin
        cfg_write(tlb_pkg::CFG_IDX, k);
        cfg_write(tlb_pkg::CFG_CMD, {30'h0, tlb_pkg::OP_READ});
      end
    end
    wait_drain();

    $display("errors: value mismatches %0d, other failures %0d", n_val_err, n_other_err);
    if (n_val_err == 0 && n_other_err == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- tb.f
hw/tlb_pkg.sv
hw/tlb_maint_if.sv
hw/tlb_lookup_if.sv
hw/tlb_cfg_regs.sv
hw/tlb_req_queue.sv
hw/tlb_entry_store.sv
hw/tlb_translate.sv
hw/tlb_top.sv
sim/tlb_chk.sv
sim/tlb_tb.sv
